// File: Makefile
# Verilator build and run, pass is decided by the log

VERILATOR  ?= verilator
TOP        ?= tb_audio_udp
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: audio_pkt/audio_pkt.sv
// two banks of pkt_words, samples arriving with both banks full are dropped
// first sample of a pair lands in the upper half of the word
`default_nettype none
`timescale 1ns/1ps

module audio_pkt (
   input  logic               clk_12M,
   input  logic               rst_n,
   input  logic               audio_en,
   input  audio_pkg::sample_t audio_data,
   udp_tx_if.src              tx,
   output logic               led
);
   import audio_pkg::*;

   logic [31:0] mem [0:2*pkt_words-1];   // bank is the top address bit

   logic                  wr_bank;
   logic [word_idx_w-1:0] wr_idx;
   logic                  half;       // upper half already held
   sample_t               hi_smp;     // first sample of the pair
   logic                  wr_ok;

   logic                  rd_bank;
   logic [word_idx_w-1:0] rd_idx;
   logic                  busy;       // frame open, start_en to done

   logic [1:0] full;
   logic [1:0] full_set;
   logic [1:0] full_clr;
   logic [1:0] full_nx;
   logic       next_rd;
   logic       start_nx;

   assign wr_ok       = audio_en && !full[wr_bank];   // drop on full bank
   assign tx.byte_num = 16'(pkt_bytes);
   assign led         = ~busy;                        // lit while sending

   always_comb
   begin
      full_set = '0;
      full_clr = '0;
      if (wr_ok && half && wr_idx == word_idx_w'(pkt_words - 1))
         full_set[wr_bank] = 1'b1;   // last word of the bank
      if (tx.done)
         full_clr[rd_bank] = 1'b1;
      full_nx  = (full | full_set) & ~full_clr;
      next_rd  = tx.done ? ~rd_bank : rd_bank;
      // new frame right after done, or as soon as a bank fills
      start_nx = (!busy || tx.done) && full_nx[next_rd];
   end

   // write side
   always_ff @(posedge clk_12M or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_bank <= 1'b0;
         wr_idx  <= '0;
         half    <= 1'b0;
      end
      else if (wr_ok)
      begin
         half <= ~half;
         if (half)
         begin
            if (wr_idx == word_idx_w'(pkt_words - 1))
            begin
               wr_idx  <= '0;
               wr_bank <= ~wr_bank;   // move to other bank
            end
            else
               wr_idx <= wr_idx + 1'b1;
         end
      end
   end

   // frame control and read side
   always_ff @(posedge clk_12M or negedge rst_n)
   begin
      if (!rst_n)
      begin
         full        <= '0;
         rd_bank     <= 1'b0;
         rd_idx      <= '0;
         busy        <= 1'b0;
         tx.start_en <= 1'b0;
      end
      else
      begin
         full        <= full_nx;
         rd_bank     <= next_rd;
         tx.start_en <= start_nx;
         busy        <= start_nx || (busy && !tx.done);
         if (tx.done)
            rd_idx <= '0;
         else if (tx.req)
            rd_idx <= rd_idx + 1'b1;
      end
   end

   // storage and read data, no reset
   always_ff @(posedge clk_12M)
   begin
      if (wr_ok && !half)
         hi_smp <= audio_data;
      if (wr_ok && half)
         mem[{wr_bank, wr_idx}] <= {hi_smp, audio_data};
      if (tx.req)
         tx.data <= mem[{rd_bank, rd_idx}];   // valid the clock after req
   end

endmodule

`default_nettype wire

// File: common/audio_pkg.sv
// audio stream sizes, all fixed at build time
// pkt_samples must be even, two samples share one payload word
`default_nettype none

package audio_pkg;

   localparam int sample_w    = 16;
   typedef logic [sample_w-1:0] sample_t;

   localparam int sample_div  = 8;          // clocks per sample
   localparam int burst_len   = 1024;       // samples per run, then silent
   localparam int pkt_samples = 32;         // samples in one frame
   localparam int pkt_words   = pkt_samples / 2;
   localparam int pkt_bytes   = pkt_samples * (sample_w / 8);

   // counter widths
   localparam int div_w       = $clog2(sample_div);
   localparam int burst_cnt_w = $clog2(burst_len + 1);
   localparam int word_idx_w  = $clog2(pkt_words);

endpackage

`default_nettype wire

// File: common/eth_pkg.sv
// fixed addresses, no ARP, destination must match the host
// header layout is plain IPv4 without options, UDP checksum always zero
`default_nettype none

package eth_pkg;

   typedef logic [7:0] byte_t;

   // one 32-bit header word, bytes for the wire and halves for the checksum
   typedef union packed {
      logic [3:0][7:0]  bytes;   // [3] goes out first
      logic [1:0][15:0] halves;
   } hdr_word_u;

   localparam logic [47:0] board_mac = 48'ha0_b1_c2_d3_e1_e1;
   localparam logic [31:0] board_ip  = {8'd192, 8'd168, 8'd1, 8'd11};
   localparam logic [47:0] des_mac   = 48'h84_a9_38_bf_c9_a0;
   localparam logic [31:0] des_ip    = {8'd169, 8'd254, 8'd51, 8'd120};
   localparam logic [15:0] src_port  = 16'd1234;
   localparam logic [15:0] des_port  = 16'd1234;

   localparam logic [15:0] eth_type_ip  = 16'h0800;
   localparam logic [7:0]  ip_ver_ihl   = 8'h45;      // v4, 5 words
   localparam logic [15:0] ip_flags_df  = 16'h4000;   // don't fragment
   localparam logic [7:0]  ip_ttl       = 8'd64;
   localparam logic [7:0]  ip_proto_udp = 8'd17;

   localparam logic [7:0] pre_byte = 8'h55;
   localparam logic [7:0] sfd_byte = 8'hd5;

   localparam int preamble_len = 7;
   localparam int eth_hdr_len  = 14;
   localparam int ip_hdr_len   = 20;
   localparam int udp_hdr_len  = 8;
   localparam int hdr_len      = eth_hdr_len + ip_hdr_len + udp_hdr_len;
   localparam int fcs_len      = 4;
   localparam int ifg_len      = 12;   // idle clocks after fcs

   localparam logic [eth_hdr_len*8-1:0] eth_hdr_bytes = {des_mac, board_mac, eth_type_ip};

   localparam logic [31:0] crc_poly_rev = 32'hedb88320;   // 0x04c11db7 reflected

   // transmit sequencer states
   localparam logic [2:0] st_idle = 3'd0;
   localparam logic [2:0] st_pre  = 3'd1;
   localparam logic [2:0] st_hdr  = 3'd2;
   localparam logic [2:0] st_pay  = 3'd3;
   localparam logic [2:0] st_fcs  = 3'd4;
   localparam logic [2:0] st_gap  = 3'd5;

endpackage

`default_nettype wire

// File: common/udp_tx_if.sv
// frame request bus, data follows req by one clock
`default_nettype none
`timescale 1ns/1ps

interface udp_tx_if;

   logic        start_en;   // one pulse per frame
   logic [15:0] byte_num;   // payload bytes, multiple of 4
   logic [31:0] data;       // payload word
   logic        req;        // word request, one pulse
   logic        done;       // end of frame and gap

   // packetizer side
   modport src (
      output start_en, byte_num, data,
      input  req, done
   );

   // transmitter side
   modport snk (
      input  start_en, byte_num, data,
      output req, done
   );

endinterface

`default_nettype wire

// File: rtl/audio_ramp_src.sv
// ramp test source, one burst of burst_len samples per reset
// divider holds while run is low so no sample value is lost
`default_nettype none
`timescale 1ns/1ps

module audio_ramp_src (
   input  logic               clk_12M,
   input  logic               rst_n,
   input  logic               run,
   output logic               audio_en,
   output audio_pkg::sample_t audio_data
);
   import audio_pkg::*;

   logic [div_w-1:0]       div_cnt;   // clocks since last strobe
   logic [burst_cnt_w-1:0] smp_cnt;   // strobes sent so far
   logic                   burst_end;

   assign burst_end = (smp_cnt == burst_cnt_w'(burst_len));

   always_ff @(posedge clk_12M or negedge rst_n)
   begin
      if (!rst_n)
      begin
         div_cnt  <= '0;
         smp_cnt  <= '0;
         audio_en <= 1'b0;
      end
      else
      begin
         audio_en <= 1'b0;   // strobe is one clock wide
         if (run && !burst_end)
         begin
            if (div_cnt == div_w'(sample_div - 1))
            begin
               div_cnt  <= '0;
               audio_en <= 1'b1;
               smp_cnt  <= smp_cnt + 1'b1;
            end
            else
               div_cnt <= div_cnt + 1'b1;
         end
      end
   end

   // value steps after each strobe, so first sample is 0
   always_ff @(posedge clk_12M or negedge rst_n)
   begin
      if (!rst_n)
         audio_data <= '0;
      else if (audio_en)
         audio_data <= audio_data + 1'b1;
   end

endmodule

`default_nettype wire

// File: rtl/audio_udp_top.sv
// ramp source to UDP over GMII, single clock, given reset
// destination MAC and IP fixed in eth_pkg
`default_nettype none
`timescale 1ns/1ps

module audio_udp_top (
   input  logic       clk_12M,
   input  logic       rst_n,
   input  logic       run,          // high lets samples flow
   output logic       gmii_tx_en,
   output logic [7:0] gmii_txd,
   output logic       led           // low during a frame
);
   import audio_pkg::*;

   logic    audio_en;
   sample_t audio_data;

   udp_tx_if tx_bus ();

   audio_ramp_src src0 (
      .clk_12M    (clk_12M),
      .rst_n      (rst_n),
      .run        (run),
      .audio_en   (audio_en),
      .audio_data (audio_data)
   );

   audio_pkt pkt0 (
      .clk_12M    (clk_12M),
      .rst_n      (rst_n),
      .audio_en   (audio_en),
      .audio_data (audio_data),
      .tx         (tx_bus.src),
      .led        (led)
   );

   udp_tx utx0 (
      .clk_12M    (clk_12M),
      .rst_n      (rst_n),
      .tx         (tx_bus.snk),
      .gmii_tx_en (gmii_tx_en),
      .gmii_txd   (gmii_txd)
   );

endmodule

`default_nettype wire

// File: sources.f
common/audio_pkg.sv
common/eth_pkg.sv
common/udp_tx_if.sv
rtl/audio_ramp_src.sv
audio_pkt/audio_pkt.sv
udp_tx/crc32_d8.sv
udp_tx/udp_tx.sv
rtl/audio_udp_top.sv
tests/tb_audio_udp.sv

// File: tests/tb_audio_udp.sv
// stimulus table drives run, every frame is rebuilt from the package constants
// needs the full burst in the table, the final row must stay quiet
`default_nettype none
`timescale 1ns/1ps

module tb_audio_udp;
   import audio_pkg::*;
   import eth_pkg::*;

   localparam int frame_len = preamble_len + 1 + hdr_len + pkt_bytes + fcs_len;   // 118
   localparam int pay_base  = preamble_len + 1 + hdr_len;
   localparam int n_rows    = 5;
   localparam int bank_clks = pkt_samples * sample_div;   // run-high clocks per frame

   typedef struct {
      logic level;    // run value for the row
      int   clocks;   // row length
      int   frames;   // cumulative frames at row end
   } row_t;

   logic       clk_12M;
   logic       rst_n;
   logic       run;
   logic       gmii_tx_en;
   logic [7:0] gmii_txd;
   logic       led;

   row_t  rows [0:n_rows-1];
   byte_t cap [$];          // bytes of the current frame
   bit    in_frame;
   int    gap_clks;         // idle clocks since last frame
   int    frames_seen;
   int    model_smp;        // next expected sample value
   logic [15:0] last_smp;   // final sample seen on the wire
   int    checks;
   int    errors;
   int    total_clks;

   audio_udp_top dut0 (
      .clk_12M    (clk_12M),
      .rst_n      (rst_n),
      .run        (run),
      .gmii_tx_en (gmii_tx_en),
      .gmii_txd   (gmii_txd),
      .led        (led)
   );

   always #50 clk_12M = ~clk_12M;   // 100 ns period

   // reflected crc-32, whole byte folded in first
   function automatic logic [31:0] crc_byte(input logic [31:0] c, input byte_t d);
      logic [31:0] r;
      r = c ^ {24'h0, d};
      repeat (8)
         r = r[0] ? ((r >> 1) ^ 32'hedb88320) : (r >> 1);
      return r;
   endfunction

   function automatic string field_name(input int idx);
      int o;
      o = idx - (preamble_len + 1);   // offset from dest mac
      if (idx < preamble_len) return "preamble";
      if (o < 0) return "sfd";
      if (o < 6) return "dest mac";
      if (o < 12) return "src mac";
      if (o < 14) return "ethertype";
      if (o < 16) return "ip version";
      if (o < 18) return "ip total length";
      if (o < 20) return "ip identification";
      if (o < 22) return "ip flags";
      if (o < 24) return "ip ttl/protocol";
      if (o < 26) return "ip checksum";
      if (o < 30) return "ip source";
      if (o < 34) return "ip destination";
      if (o < 38) return "udp ports";
      if (o < 40) return "udp length";
      if (o < 42) return "udp checksum";
      if (o < hdr_len + pkt_bytes) return "payload";
      return "fcs";
   endfunction

   task automatic check_byte(input int idx, input byte_t expv, input byte_t act);
      checks++;
      assert (act === expv)
      else
      begin
         errors++;
         $display("** Error at %0d ns: gmii_txd (%s byte %0d) expected %02h got %02h",
                  $time, field_name(idx), idx, expv, act);
      end
   endtask

   // model frame from the rules, then byte compare
   task automatic check_frame();
      byte_t       exp [0:frame_len-1];
      logic [15:0] h [0:9];
      logic [31:0] sum;
      logic [31:0] crc;
      logic [15:0] s;
      logic [hdr_len*8-1:0] hdr;
      h[0] = 16'h4500;                                       // v4, ihl 5, tos 0
      h[1] = 16'(pkt_bytes + ip_hdr_len + udp_hdr_len);
      h[2] = 16'(frames_seen);                               // id counts from 0
      h[3] = 16'h4000;                                       // DF
      h[4] = {ip_ttl, ip_proto_udp};
      h[5] = 16'h0000;
      h[6] = board_ip[31:16];
      h[7] = board_ip[15:0];
      h[8] = des_ip[31:16];
      h[9] = des_ip[15:0];
      sum = 32'h0;
      for (int i = 0; i < 10; i++)
         sum = sum + 32'(h[i]);
      while (sum[31:16] != 16'h0)
         sum = (sum & 32'hffff) + (sum >> 16);              // end-around carry
      h[5] = ~sum[15:0];
      hdr = {des_mac, board_mac, eth_type_ip, h[0], h[1], h[2], h[3], h[4], h[5], h[6],
             h[7], h[8], h[9], src_port, des_port, 16'(pkt_bytes + udp_hdr_len), 16'h0000};
      for (int i = 0; i < preamble_len; i++)
         exp[i] = 8'h55;
      exp[preamble_len] = 8'hd5;
      for (int i = 0; i < hdr_len; i++)
         exp[preamble_len + 1 + i] = hdr[(hdr_len - 1 - i) * 8 +: 8];
      for (int w = 0; w < pkt_samples; w++)
      begin
         s = 16'(model_smp + w);
         exp[pay_base + 2 * w]     = s[15:8];   // big endian samples
         exp[pay_base + 2 * w + 1] = s[7:0];
      end
      crc = 32'hffffffff;
      for (int i = preamble_len + 1; i < pay_base + pkt_bytes; i++)
         crc = crc_byte(crc, exp[i]);
      crc = ~crc;
      for (int i = 0; i < fcs_len; i++)
         exp[pay_base + pkt_bytes + i] = crc[i * 8 +: 8];   // lsb first
      checks++;
      assert (cap.size() == frame_len)
      else
      begin
         errors++;
         $display("frame %0d has %0d bytes instead of %0d", frames_seen, cap.size(), frame_len);
      end
      if (cap.size() == frame_len)
      begin
         for (int i = 0; i < frame_len; i++)
            check_byte(i, exp[i], cap[i]);
         last_smp = {cap[pay_base + pkt_bytes - 2], cap[pay_base + pkt_bytes - 1]};
      end
      frames_seen++;
      model_smp += pkt_samples;
   endtask

   // frame monitor, sampled mid-cycle
   always @(negedge clk_12M)
   begin
      if (rst_n)
      begin
         if (gmii_tx_en)
         begin
            if (!in_frame)
            begin
               checks++;
               assert (frames_seen == 0 || gap_clks >= ifg_len)
               else
               begin
                  errors++;
                  $display("gap before frame %0d only %0d clocks", frames_seen, gap_clks);
               end
               cap.delete();
            end
            in_frame = 1'b1;
            cap.push_back(gmii_txd);
            checks++;
            assert (led == 1'b0)
            else
            begin
               errors++;
               $display("** Error at %0d ns: led expected 0 got %0b", $time, led);
            end
         end
         else
         begin
            if (in_frame)
            begin
               check_frame();
               gap_clks = 0;
            end
            in_frame = 1'b0;
            gap_clks++;
         end
      end
   end

   // watchdog, table length plus margin
   initial
   begin
      wait (total_clks != 0);
      #(longint'(total_clks + 2000) * 100);
      $display("timeout, run still going after %0d clocks", total_clks + 2000);
      $display("Test FAILED");
      $finish;
   end

   initial
   begin
      int err_before;
      void'($urandom(33370));
      clk_12M     = 1'b0;
      rst_n       = 1'b0;
      run         = 1'b0;
      in_frame    = 1'b0;
      gap_clks    = 0;
      frames_seen = 0;
      model_smp   = 0;
      last_smp    = '0;
      checks      = 0;
      errors      = 0;
      rows[0] = '{1'b0, 200, 0};                                   // idle
      rows[1] = '{1'b1, 4 * bank_clks + 200, 4};
      rows[2] = '{1'b0, 50 + int'($urandom % 500), 4};             // pause mid bank
      rows[3] = '{1'b1, (burst_len / pkt_samples - 4) * bank_clks + 300,
                  burst_len / pkt_samples};
      rows[4] = '{1'b1, 3000, burst_len / pkt_samples};            // burst over
      total_clks = 3;
      for (int r = 0; r < n_rows; r++)
         total_clks += rows[r].clocks;
      repeat (3) @(posedge clk_12M);
      #1 rst_n = 1'b1;
      for (int r = 0; r < n_rows; r++)
      begin
         err_before = errors;
         for (int c = 0; c < rows[r].clocks; c++)
         begin
            @(posedge clk_12M);
            #1 run = rows[r].level;
            if (!rows[r].level)
            begin
               checks++;
               assert (!gmii_tx_en && led)
               else
               begin
                  errors++;
                  $display("** Error at %0d ns: gmii_tx_en/led expected 0/1 got %0b/%0b",
                           $time, gmii_tx_en, led);
               end
            end
         end
         checks++;
         assert (frames_seen == rows[r].frames)
         else
         begin
            errors++;
            $display("** Error at %0d ns: frame count expected %0d got %0d",
                     $time, rows[r].frames, frames_seen);
         end
         $display("row %0d: run %0b for %0d clocks, %0d frames, %0d errors",
                  r, rows[r].level, rows[r].clocks, frames_seen, errors - err_before);
      end
      checks++;
      assert (last_smp === 16'(burst_len - 1))   // last payload ends the burst
      else
      begin
         errors++;
         $display("last payload sample was %0d instead of %0d", last_smp, burst_len - 1);
      end
      $display("checks %0d, errors %0d, frames %0d", checks, errors, frames_seen);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: udp_tx/crc32_d8.sv
// reflected ethernet crc-32, bit 0 of each byte first
// output is the raw register, complement before sending
`default_nettype none
`timescale 1ns/1ps

module crc32_d8 (
   input  logic           clk_12M,
   input  logic           rst_n,
   input  logic           init,      // preset to all ones
   input  logic           byte_en,
   input  eth_pkg::byte_t byte_in,
   output logic [31:0]    crc
);
   import eth_pkg::*;

   function automatic logic [31:0] crc_step(input logic [31:0] c, input byte_t d);
      logic [31:0] r;
      r = c;
      for (int i = 0; i < 8; i++)
      begin
         if (r[0] ^ d[i])
            r = (r >> 1) ^ crc_poly_rev;
         else
            r = r >> 1;
      end
      return r;
   endfunction

   always_ff @(posedge clk_12M or negedge rst_n)
   begin
      if (!rst_n)
         crc <= '1;
      else if (init)
         crc <= '1;
      else if (byte_en)
         crc <= crc_step(crc, byte_in);
   end

endmodule

`default_nettype wire

// File: udp_tx/udp_tx.sv
// one UDP frame per start_en, byte_num must be a nonzero multiple of 4
// GMII outputs are decoded from state, no RGMII or receive path
`default_nettype none
`timescale 1ns/1ps

module udp_tx (
   input  logic          clk_12M,
   input  logic          rst_n,
   udp_tx_if.snk         tx,
   output logic          gmii_tx_en,
   output eth_pkg::byte_t gmii_txd
);
   import eth_pkg::*;

   localparam int ip_halves = ip_hdr_len / 2;
   localparam int hdr_words = (ip_hdr_len + udp_hdr_len) / 4;

   logic [2:0]  st;
   logic [15:0] cnt;        // byte count inside the state
   logic [15:0] len_q;      // latched payload length
   logic [15:0] frame_id;   // ip identification
   logic        start;

   hdr_word_u hdr_w [0:hdr_words-1];   // ip words then udp words
   hdr_word_u hw;                      // word on the wire
   hdr_word_u pay_w;
   logic [15:0] hdr_off;

   logic [3:0]  sum_idx;
   logic [15:0] csum;
   logic [16:0] sum_acc;

   logic        crc_en;
   logic [31:0] crc;

   assign start   = (st == st_idle) && tx.start_en;
   assign hdr_off = cnt - 16'(eth_hdr_len);
   assign pay_w   = tx.data;
   assign crc_en  = (st == st_hdr) || (st == st_pay);   // dest mac through payload

   assign gmii_tx_en = (st == st_pre) || (st == st_hdr) || (st == st_pay) || (st == st_fcs);
   assign tx.done    = (st == st_gap) && (cnt == 16'(ifg_len - 1));
   // ask one clock before each payload word
   assign tx.req = ((st == st_hdr) && (cnt == 16'(hdr_len - 1))) ||
                   ((st == st_pay) && (cnt[1:0] == 2'd3) && (cnt != len_q - 16'd1));

   // sequencer
   always_ff @(posedge clk_12M or negedge rst_n)
   begin
      if (!rst_n)
      begin
         st       <= st_idle;
         cnt      <= '0;
         frame_id <= '0;
      end
      else
      begin
         cnt <= cnt + 1'b1;
         case (st)
            st_idle:
            begin
               cnt <= '0;
               if (tx.start_en)
               begin
                  st       <= st_pre;
                  frame_id <= frame_id + 1'b1;
               end
            end
            st_pre:
               if (cnt == 16'(preamble_len))   // sfd is the last one
               begin
                  st  <= st_hdr;
                  cnt <= '0;
               end
            st_hdr:
               if (cnt == 16'(hdr_len - 1))
               begin
                  st  <= st_pay;
                  cnt <= '0;
               end
            st_pay:
               if (cnt == len_q - 16'd1)
               begin
                  st  <= st_fcs;
                  cnt <= '0;
               end
            st_fcs:
               if (cnt == 16'(fcs_len - 1))
               begin
                  st  <= st_gap;
                  cnt <= '0;
               end
            st_gap:
               if (tx.done)
               begin
                  st  <= st_idle;
                  cnt <= '0;
               end
            default:
               st <= st_idle;
         endcase
      end
   end

   // header words, built once per frame
   always_ff @(posedge clk_12M)
   begin
      if (start)
      begin
         len_q    <= tx.byte_num;
         hdr_w[0] <= {ip_ver_ihl, 8'h00, tx.byte_num + 16'(ip_hdr_len + udp_hdr_len)};
         hdr_w[1] <= {frame_id, ip_flags_df};
         hdr_w[2] <= {ip_ttl, ip_proto_udp, 16'h0000};   // checksum slot empty
         hdr_w[3] <= board_ip;
         hdr_w[4] <= des_ip;
         hdr_w[5] <= {src_port, des_port};
         hdr_w[6] <= {tx.byte_num + 16'(udp_hdr_len), 16'h0000};   // no udp checksum
      end
   end

   // ip checksum, one half per clock during the preamble
   assign sum_acc = {1'b0, csum} + {1'b0, hdr_w[sum_idx[3:1]].halves[~sum_idx[0]]};

   always_ff @(posedge clk_12M or negedge rst_n)
   begin
      if (!rst_n)
      begin
         sum_idx <= 4'(ip_halves);
         csum    <= '0;
      end
      else if (start)
      begin
         sum_idx <= '0;
         csum    <= '0;
      end
      else if (sum_idx != 4'(ip_halves))
      begin
         sum_idx <= sum_idx + 1'b1;
         csum    <= sum_acc[15:0] + 16'(sum_acc[16]);   // end-around carry
      end
   end

   // byte mux
   always_comb
   begin
      hw = hdr_w[hdr_off[4:2]];
      if (hdr_off[4:2] == 3'd2)
         hw.halves[0] = ~csum;
      gmii_txd = 8'h00;
      case (st)
         st_pre:
            gmii_txd = (cnt == 16'(preamble_len)) ? sfd_byte : pre_byte;
         st_hdr:
            if (cnt < 16'(eth_hdr_len))
               gmii_txd = eth_hdr_bytes[(eth_hdr_len - 1 - cnt) * 8 +: 8];
            else
               gmii_txd = hw.bytes[~hdr_off[1:0]];   // msb first
         st_pay:
            gmii_txd = pay_w.bytes[~cnt[1:0]];
         st_fcs:
            gmii_txd = ~crc[cnt[1:0] * 8 +: 8];      // lsb first
         default:
            gmii_txd = 8'h00;
      endcase
   end

   crc32_d8 crc0 (
      .clk_12M (clk_12M),
      .rst_n   (rst_n),
      .init    (start),
      .byte_en (crc_en),
      .byte_in (gmii_txd),
      .crc     (crc)
   );

endmodule

`default_nettype wire
